//--- compile.f
riscv_pkg.sv
riscv_alu.sv
riscv_mul.sv
riscv_icu.sv
riscv_lsu.sv
riscv_misalignment_unit.sv
riscv_estage.sv
tb_riscv_estage.sv

//--- Bender.yml
package:
  name: riscv_estage

sources:
  - riscv_pkg.sv
  - riscv_alu.sv
  - riscv_mul.sv
  - riscv_icu.sv
  - riscv_lsu.sv
  - riscv_misalignment_unit.sv
  - riscv_estage.sv
  - target: simulation
    files:
      - tb_riscv_estage.sv

//--- tb_riscv_estage.sv
`timescale 1ns/1ps

module tb_riscv_estage;

  typedef logic [riscv_pkg::XLEN-1:0] word_t;

  localparam int CLK_PERIOD  = 40;
  localparam int N_ALU       = 200;
  localparam int N_BRANCH    = 100;
  localparam int N_LDST      = 100;
  localparam int N_TRAP      = 20;
  localparam int N_MUL       = 15;                       // Three passes over the five forms
  localparam int N_ATOMIC    = 8;
  localparam int N_TESTS     = N_ALU + N_BRANCH + N_LDST + N_TRAP + N_MUL + N_ATOMIC;
  localparam int WATCHDOG_NS = N_TESTS * (riscv_pkg::MUL_CYCLES + 4) * CLK_PERIOD;

  localparam riscv_pkg::bcond_e BCONDS [8] = '{
    riscv_pkg::BC_NONE, riscv_pkg::BC_BEQ, riscv_pkg::BC_BNE, riscv_pkg::BC_JUMP,
    riscv_pkg::BC_BLT, riscv_pkg::BC_BGE, riscv_pkg::BC_BLTU, riscv_pkg::BC_BGEU
  };

  logic                   clk;
  logic                   rst_n;
  logic                   globstall;
  riscv_pkg::ex_ctrl_t    ex_ctrl;
  riscv_pkg::mem_ctrl_t   mem_ctrl;
  word_t                  rs1data;
  word_t                  rs2data;
  word_t                  rdata_wb;
  word_t                  rddata_m;
  word_t                  imm_m;
  word_t                  pc;
  word_t                  simm;
  word_t                  immextended;
  logic                   gtrap;
  logic [1:0]             rtrap;
  word_t                  result;
  word_t                  store_data;
  logic                   branchtaken;
  logic                   mul_busy;
  logic                   icu_valid;
  word_t                  csrwritedata;
  riscv_pkg::mem_req_t    mem_req;
  riscv_pkg::trap_flags_t trap_flags;
  word_t                  rddata_sc;
  logic [31:0]            rng_state;
  int                     value_errs;
  int                     other_errs;

  riscv_estage u_dut (
    .i_riscv_estage_clk (clk),
    .i_rst_n            (rst_n),
    .i_globstall        (globstall),
    .i_ex_ctrl          (ex_ctrl),
    .i_mem_ctrl         (mem_ctrl),
    .i_rs1data          (rs1data),
    .i_rs2data          (rs2data),
    .i_rdata_wb         (rdata_wb),
    .i_rddata_m         (rddata_m),
    .i_imm_m            (imm_m),
    .i_pc               (pc),
    .i_simm             (simm),
    .i_immextended      (immextended),
    .i_gtrap            (gtrap),
    .i_rtrap            (rtrap),
    .o_result           (result),
    .o_store_data       (store_data),
    .o_branchtaken      (branchtaken),
    .o_mul_busy         (mul_busy),
    .o_icu_valid        (icu_valid),
    .o_csrwritedata     (csrwritedata),
    .o_mem_req          (mem_req),
    .o_trap_flags       (trap_flags),
    .o_rddata_sc        (rddata_sc)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog timeout, the tests did not complete in time");
    $display("TB FAILED");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int unsigned rand_below(int unsigned n);
    return (lcg_next() >> 8) % n;                        // Low LCG bits repeat quickly
  endfunction

  function automatic word_t rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi, lo};
  endfunction

  function automatic word_t pick_fwd(riscv_pkg::fwd_sel_e sel, word_t regval);
    case (sel)
      riscv_pkg::FWD_WB:    return rdata_wb;
      riscv_pkg::FWD_MEM:   return rddata_m;
      riscv_pkg::FWD_IMM_M: return imm_m;
      default:              return regval;
    endcase
  endfunction

  function automatic word_t alu_model(riscv_pkg::alu_op_e op, word_t a, word_t b);
    logic [31:0] w;
    w = 32'h0;
    case (op)
      riscv_pkg::ALU_ADD:  return a + b;
      riscv_pkg::ALU_SUB:  return a - b;
      riscv_pkg::ALU_SLL:  return a << b[5:0];
      riscv_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      riscv_pkg::ALU_SLTU: return (a < b) ? 64'd1 : 64'd0;
      riscv_pkg::ALU_XOR:  return a ^ b;
      riscv_pkg::ALU_SRL:  return a >> b[5:0];
      riscv_pkg::ALU_SRA:  return $signed(a) >>> b[5:0];
      riscv_pkg::ALU_OR:   return a | b;
      riscv_pkg::ALU_AND:  return a & b;
      riscv_pkg::ALU_ADDW: w = a[31:0] + b[31:0];
      riscv_pkg::ALU_SUBW: w = a[31:0] - b[31:0];
      riscv_pkg::ALU_SLLW: w = a[31:0] << b[4:0];
      riscv_pkg::ALU_SRLW: w = a[31:0] >> b[4:0];
      riscv_pkg::ALU_SRAW: w = $signed(a[31:0]) >>> b[4:0];
      riscv_pkg::ALU_LUI:  return b;
      riscv_pkg::ALU_JAL:  return a + 64'd4;
      default:             return 64'h0;
    endcase
    return {{32{w[31]}}, w};                             // Word forms only
  endfunction

  function automatic logic cond_model(riscv_pkg::bcond_e bc, word_t a, word_t b);
    case (bc)
      riscv_pkg::BC_BEQ:  return a == b;
      riscv_pkg::BC_BNE:  return a != b;
      riscv_pkg::BC_BLT:  return $signed(a) < $signed(b);
      riscv_pkg::BC_BGE:  return $signed(a) >= $signed(b);
      riscv_pkg::BC_BLTU: return a < b;
      riscv_pkg::BC_BGEU: return a >= b;
      riscv_pkg::BC_JUMP: return 1'b1;
      default:            return 1'b0;
    endcase
  endfunction

  // Full 128-bit product of the sign- or zero-extended operands
  function automatic word_t mul_model(riscv_pkg::mul_op_e op, word_t a, word_t b);
    logic [127:0] ea;
    logic [127:0] eb;
    logic [127:0] p;
    ea = {{64{a[63] && (op == riscv_pkg::MUL_MULH || op == riscv_pkg::MUL_MULHSU)}}, a};
    eb = {{64{b[63] && (op == riscv_pkg::MUL_MULH)}}, b};
    p  = ea * eb;
    case (op)
      riscv_pkg::MUL_MUL:  return p[63:0];
      riscv_pkg::MUL_MULW: return {{32{p[31]}}, p[31:0]};
      default:             return p[127:64];
    endcase
  endfunction

  task automatic report_value(string name, word_t got, word_t exp);
    value_errs++;
    $display("Error: %s is 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
  endtask

  task automatic drive_random_data(logic equal_pair);
    word_t v;
    v = rand64();
    rs1data     <= v;
    rs2data     <= equal_pair ? v : rand64();
    rdata_wb    <= rand64();
    rddata_m    <= rand64();
    imm_m       <= rand64();
    pc          <= rand64() & ~64'h3;                    // No compressed instructions
    simm        <= rand64();
    immextended <= rand64();
  endtask

  task automatic run_alu_tests();
    riscv_pkg::ex_ctrl_t c;
    word_t               fa;
    word_t               fb;
    word_t               exp_y;
    word_t               exp_csr;
    int                  i;
    for (i = 0; i < N_ALU; i++) begin
      c           = '0;
      c.fwda      = riscv_pkg::fwd_sel_e'(rand_below(4));
      c.fwdb      = riscv_pkg::fwd_sel_e'(rand_below(4));
      c.oprnd1sel = rand_below(2) != 0;
      c.oprnd2sel = rand_below(2) != 0;
      c.aluop     = riscv_pkg::alu_op_e'(rand_below(17));
      c.funcsel   = riscv_pkg::FUNC_ALU;
      c.imm_reg   = rand_below(2) != 0;
      @(posedge clk);
      ex_ctrl <= c;
      drive_random_data(1'b0);
      @(negedge clk);
      fa      = pick_fwd(c.fwda, rs1data);
      fb      = pick_fwd(c.fwdb, rs2data);
      exp_y   = alu_model(c.aluop, c.oprnd1sel ? fa : pc, c.oprnd2sel ? simm : fb);
      exp_csr = c.imm_reg ? immextended : fa;
      if (result !== exp_y) report_value("o_result", result, exp_y);
      if (icu_valid !== 1'b1) report_value("o_icu_valid", icu_valid, 1);
      if (store_data !== fb) report_value("o_store_data", store_data, fb);
      if (csrwritedata !== exp_csr) report_value("o_csrwritedata", csrwritedata, exp_csr);
      if (branchtaken !== 1'b0) report_value("o_branchtaken", branchtaken, 0);
      if (trap_flags !== 3'b000) report_value("o_trap_flags", trap_flags, 0);
      if (mem_req.wren !== 1'b0) report_value("o_mem_req.wren", mem_req.wren, 0);
      if (mem_req.rden !== 1'b0) report_value("o_mem_req.rden", mem_req.rden, 0);
    end
  endtask

  task automatic run_branch_tests();
    riscv_pkg::ex_ctrl_t c;
    word_t               target;
    logic                taken;
    int                  i;
    for (i = 0; i < N_BRANCH; i++) begin
      c           = '0;
      c.bcond     = BCONDS[rand_below(8)];
      c.is_jump   = (c.bcond == riscv_pkg::BC_JUMP);
      c.is_branch = c.bcond[3] && !c.is_jump;
      c.oprnd2sel = 1'b1;                                // Target is PC plus offset
      c.aluop     = riscv_pkg::ALU_ADD;
      c.funcsel   = riscv_pkg::FUNC_ALU;
      @(posedge clk);
      ex_ctrl <= c;
      drive_random_data(rand_below(2) != 0);
      @(negedge clk);
      target = pc + simm;
      taken  = (c.is_branch || c.is_jump) && cond_model(c.bcond, rs1data, rs2data);
      if (result !== target) report_value("o_result", result, target);
      if (branchtaken !== taken) report_value("o_branchtaken", branchtaken, taken);
      if (trap_flags.inst !== (target[1] && taken)) begin
        report_value("o_trap_flags.inst", trap_flags.inst, target[1] && taken);
      end
    end
  endtask

  task automatic run_ldst_tests(logic with_trap);
    riscv_pkg::ex_ctrl_t  c;
    riscv_pkg::mem_ctrl_t m;
    word_t                addr;
    logic                 mis;
    logic [1:0]           rt;
    logic                 gt;
    int                   i;
    for (i = 0; i < (with_trap ? N_TRAP : N_LDST); i++) begin
      c           = '0;
      c.oprnd1sel = 1'b1;
      c.oprnd2sel = 1'b1;
      c.aluop     = riscv_pkg::ALU_ADD;
      c.funcsel   = riscv_pkg::FUNC_ALU;
      m           = '0;
      m.size      = riscv_pkg::mem_size_e'(rand_below(4));
      m.memr      = rand_below(2) != 0;
      m.memw      = !m.memr;
      gt          = with_trap && (rand_below(2) != 0);
      rt          = with_trap ? 2'(gt ? rand_below(4) : 1 + rand_below(3)) : 2'b00;
      @(posedge clk);
      ex_ctrl  <= c;
      mem_ctrl <= m;
      gtrap    <= gt;
      rtrap    <= rt;
      drive_random_data(1'b0);
      @(negedge clk);
      addr = rs1data + simm;
      mis  = (addr % (64'd1 << m.size)) != 0;
      if (mem_req.addr !== addr) report_value("o_mem_req.addr", mem_req.addr, addr);
      if (mem_req.rden !== (m.memr && !with_trap)) begin
        report_value("o_mem_req.rden", mem_req.rden, m.memr && !with_trap);
      end
      if (mem_req.wren !== (m.memw && !with_trap)) begin
        report_value("o_mem_req.wren", mem_req.wren, m.memw && !with_trap);
      end
      if (trap_flags !== {1'b0, m.memr && mis, m.memw && mis}) begin
        report_value("o_trap_flags", trap_flags, {1'b0, m.memr && mis, m.memw && mis});
      end
    end
    @(posedge clk);
    mem_ctrl <= '0;
    gtrap    <= 1'b0;
    rtrap    <= 2'b00;
  endtask

  task automatic run_mul_tests();
    riscv_pkg::ex_ctrl_t c;
    word_t               a;
    word_t               b;
    word_t               exp_y;
    int                  edges;
    int                  k;
    for (k = 0; k < N_MUL; k++) begin
      c         = '0;
      c.mulop   = riscv_pkg::mul_op_e'(1 + k % 5);
      c.funcsel = riscv_pkg::FUNC_MUL;
      a         = rand64();
      b         = rand64();
      if (k / 5 == 1) begin
        a[63] = 1'b1;                                    // Negative times positive
        b[63] = 1'b0;
      end else if (k / 5 == 2) begin
        a[63] = 1'b0;
        b[63] = 1'b1;
      end
      @(posedge clk);
      ex_ctrl   <= c;
      rs1data   <= a;
      rs2data   <= b;
      globstall <= 1'b0;
      @(posedge clk);                                    // Start edge
      globstall <= 1'b1;                                 // Hazard logic holds the stage
      rs1data   <= rand64();
      rs2data   <= rand64();
      edges = 0;
      @(negedge clk);
      while (icu_valid !== 1'b1 && edges <= riscv_pkg::MUL_CYCLES + 4) begin
        if (mul_busy !== 1'b1) report_value("o_mul_busy", mul_busy, 1);
        @(posedge clk);
        edges++;
        @(negedge clk);
      end
      exp_y = mul_model(c.mulop, a, b);
      if (icu_valid !== 1'b1) begin
        other_errs++;
        $display("Multiply %s never raised o_icu_valid", c.mulop.name());
      end else if (edges != riscv_pkg::MUL_CYCLES + 1) begin
        other_errs++;
        $display("Multiply %s took %0d edges instead of %0d", c.mulop.name(), edges,
                 riscv_pkg::MUL_CYCLES + 1);
      end
      if (result !== exp_y) report_value("o_result", result, exp_y);
      if (mul_busy !== 1'b0) report_value("o_mul_busy", mul_busy, 0);
      @(posedge clk);
      ex_ctrl   <= '0;
      globstall <= 1'b0;
      @(negedge clk);
      if (icu_valid !== 1'b0) report_value("o_icu_valid", icu_valid, 0);
      if (mul_busy !== 1'b0) report_value("o_mul_busy", mul_busy, 0);
    end
  endtask

  task automatic atomic_step(logic lr, logic sc, logic trap, word_t addr, logic exp_ok);
    riscv_pkg::ex_ctrl_t  c;
    riscv_pkg::mem_ctrl_t m;
    c           = '0;
    c.oprnd1sel = 1'b1;
    c.funcsel   = riscv_pkg::FUNC_ALU;
    m           = '0;
    m.size      = riscv_pkg::SIZE_DOUBLE;
    m.lr        = lr ? 2'b11 : 2'b00;
    m.sc        = sc ? 2'b11 : 2'b00;
    m.memr      = lr;
    m.memw      = sc;
    @(posedge clk);
    ex_ctrl  <= c;
    mem_ctrl <= m;
    gtrap    <= trap;
    rs1data  <= addr;
    rs2data  <= '0;
    @(negedge clk);
    if ((lr || sc) && mem_req.addr !== addr) report_value("o_mem_req.addr", mem_req.addr, addr);
    if (mem_req.rden !== (lr && !trap)) report_value("o_mem_req.rden", mem_req.rden, lr);
    if (sc) begin
      if (rddata_sc !== (exp_ok ? 64'd0 : 64'd1)) report_value("o_rddata_sc", rddata_sc, !exp_ok);
      if (mem_req.wren !== exp_ok) report_value("o_mem_req.wren", mem_req.wren, exp_ok);
    end
  endtask

  task automatic run_atomic_tests();
    word_t a0;
    word_t a1;
    a0 = rand64() & ~64'h7;
    a1 = a0 ^ 64'h40;
    atomic_step(1'b1, 1'b0, 1'b0, a0, 1'b0);
    atomic_step(1'b0, 1'b1, 1'b0, a0, 1'b1);             // Matching SC succeeds
    atomic_step(1'b0, 1'b1, 1'b0, a0, 1'b0);             // Reservation already used
    atomic_step(1'b1, 1'b0, 1'b0, a0, 1'b0);
    atomic_step(1'b0, 1'b1, 1'b0, a1, 1'b0);             // Other address
    atomic_step(1'b1, 1'b0, 1'b0, a0, 1'b0);
    atomic_step(1'b0, 1'b0, 1'b1, a0, 1'b0);             // Trap drops the reservation
    atomic_step(1'b0, 1'b1, 1'b0, a0, 1'b0);
    @(posedge clk);
    mem_ctrl <= '0;
    ex_ctrl  <= '0;
  endtask

  initial begin
    rng_state   = 32'h2fe0_e251;
    value_errs  = 0;
    other_errs  = 0;
    rst_n       = 1'b0;
    globstall   = 1'b0;
    ex_ctrl     = '0;
    mem_ctrl    = '0;
    rs1data     = '0;
    rs2data     = '0;
    rdata_wb    = '0;
    rddata_m    = '0;
    imm_m       = '0;
    pc          = '0;
    simm        = '0;
    immextended = '0;
    gtrap       = 1'b0;
    rtrap       = 2'b00;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (icu_valid !== 1'b0) report_value("o_icu_valid", icu_valid, 0);
    if (mul_busy !== 1'b0) report_value("o_mul_busy", mul_busy, 0);
    if (mem_req.wren !== 1'b0) report_value("o_mem_req.wren", mem_req.wren, 0);
    if (mem_req.rden !== 1'b0) report_value("o_mem_req.rden", mem_req.rden, 0);
    run_alu_tests();
    run_branch_tests();
    run_ldst_tests(1'b0);
    run_ldst_tests(1'b1);
    run_mul_tests();
    run_atomic_tests();
    $display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- riscv_estage.sv
`timescale 1ns/1ps

module riscv_estage (
  input  logic                          i_riscv_estage_clk,
  input  logic                          i_rst_n,
  input  logic                          i_globstall,
  input  riscv_pkg::ex_ctrl_t           i_ex_ctrl,
  input  riscv_pkg::mem_ctrl_t          i_mem_ctrl,
  input  logic [riscv_pkg::XLEN-1:0]    i_rs1data,
  input  logic [riscv_pkg::XLEN-1:0]    i_rs2data,
  input  logic [riscv_pkg::XLEN-1:0]    i_rdata_wb,
  input  logic [riscv_pkg::XLEN-1:0]    i_rddata_m,
  input  logic [riscv_pkg::XLEN-1:0]    i_imm_m,
  input  logic [riscv_pkg::XLEN-1:0]    i_pc,
  input  logic [riscv_pkg::XLEN-1:0]    i_simm,
  input  logic [riscv_pkg::XLEN-1:0]    i_immextended,
  input  logic                          i_gtrap,
  input  logic [1:0]                    i_rtrap,
  output logic [riscv_pkg::XLEN-1:0]    o_result,
  output logic [riscv_pkg::XLEN-1:0]    o_store_data,
  output logic                          o_branchtaken,
  output logic                          o_mul_busy,
  output logic                          o_icu_valid,
  output logic [riscv_pkg::XLEN-1:0]    o_csrwritedata,
  output riscv_pkg::mem_req_t           o_mem_req,
  output riscv_pkg::trap_flags_t        o_trap_flags,
  output logic [riscv_pkg::XLEN-1:0]    o_rddata_sc
);

  logic [riscv_pkg::XLEN-1:0] fwd_a;
  logic [riscv_pkg::XLEN-1:0] fwd_b;
  logic [riscv_pkg::XLEN-1:0] alu_a;
  logic [riscv_pkg::XLEN-1:0] alu_b;
  logic [riscv_pkg::XLEN-1:0] icu_result;
  logic                       icu_taken;
  logic                       branch_taken;

  function automatic logic [riscv_pkg::XLEN-1:0] fwd_mux(
    input riscv_pkg::fwd_sel_e       sel,
    input logic [riscv_pkg::XLEN-1:0] regval,
    input logic [riscv_pkg::XLEN-1:0] wbval,
    input logic [riscv_pkg::XLEN-1:0] memval,
    input logic [riscv_pkg::XLEN-1:0] immval
  );
    case (sel)
      riscv_pkg::FWD_WB:    return wbval;
      riscv_pkg::FWD_MEM:   return memval;
      riscv_pkg::FWD_IMM_M: return immval;                // LUI/AUIPC value still in M
      default:              return regval;
    endcase
  endfunction

  assign fwd_a = fwd_mux(i_ex_ctrl.fwda, i_rs1data, i_rdata_wb, i_rddata_m, i_imm_m);
  assign fwd_b = fwd_mux(i_ex_ctrl.fwdb, i_rs2data, i_rdata_wb, i_rddata_m, i_imm_m);

  assign alu_a = i_ex_ctrl.oprnd1sel ? fwd_a : i_pc;
  assign alu_b = i_ex_ctrl.oprnd2sel ? i_simm : fwd_b;

  assign o_store_data   = fwd_b;
  assign o_csrwritedata = i_ex_ctrl.imm_reg ? i_immextended : fwd_a;  // CSRxxI forms
  assign o_result       = icu_result;

  // Comparator only counts for control-flow instructions
  assign branch_taken  = icu_taken & (i_ex_ctrl.is_branch | i_ex_ctrl.is_jump);
  assign o_branchtaken = branch_taken;

  riscv_icu u_icu (
    .i_riscv_icu_clk (i_riscv_estage_clk),
    .i_rst_n         (i_rst_n),
    .i_globstall     (i_globstall),
    .i_rs1data       (fwd_a),
    .i_rs2data       (fwd_b),
    .i_alua          (alu_a),
    .i_alub          (alu_b),
    .i_aluop         (i_ex_ctrl.aluop),
    .i_mulop         (i_ex_ctrl.mulop),
    .i_funcsel       (i_ex_ctrl.funcsel),
    .i_bcond         (i_ex_ctrl.bcond),
    .o_branch_taken  (icu_taken),
    .o_mul_busy      (o_mul_busy),
    .o_valid         (o_icu_valid),
    .o_result        (icu_result)
  );

  riscv_lsu u_lsu (
    .i_riscv_lsu_clk (i_riscv_estage_clk),
    .i_rst_n         (i_rst_n),
    .i_globstall     (i_globstall),
    .i_addr          (icu_result),
    .i_amo_addr      (fwd_a),                          // Atomics use rs1 directly
    .i_mem_ctrl      (i_mem_ctrl),
    .i_gtrap         (i_gtrap),
    .i_rtrap         (i_rtrap),
    .o_mem_req       (o_mem_req),
    .o_sc_rdvalue    (o_rddata_sc)
  );

  riscv_misalignment_unit u_misalignment_unit (
    .i_result        (icu_result),
    .i_branch_taken  (branch_taken),
    .i_mem_ctrl      (i_mem_ctrl),
    .i_is_jump       (i_ex_ctrl.is_jump),
    .o_flags         (o_trap_flags)
  );

endmodule

//--- riscv_misalignment_unit.sv
`timescale 1ns/1ps

module riscv_misalignment_unit (
  input  logic [riscv_pkg::XLEN-1:0] i_result,
  input  logic                       i_branch_taken,
  input  riscv_pkg::mem_ctrl_t       i_mem_ctrl,
  input  logic                       i_is_jump,
  output riscv_pkg::trap_flags_t     o_flags
);

  logic addr_misaligned;

  always_comb begin
    case (i_mem_ctrl.size)
      riscv_pkg::SIZE_HALF:   addr_misaligned = i_result[0];
      riscv_pkg::SIZE_WORD:   addr_misaligned = |i_result[1:0];
      riscv_pkg::SIZE_DOUBLE: addr_misaligned = |i_result[2:0];
      default:                addr_misaligned = 1'b0;      // Bytes always aligned
    endcase
  end

  // Jumps redirect even without a comparator setup, no C extension
  assign o_flags.inst  = i_result[1] & (i_branch_taken | i_is_jump);
  assign o_flags.load  = i_mem_ctrl.memr & addr_misaligned;
  assign o_flags.store = i_mem_ctrl.memw & addr_misaligned;

endmodule

//--- riscv_lsu.sv
`timescale 1ns/1ps

module riscv_lsu (
  input  logic                       i_riscv_lsu_clk,
  input  logic                       i_rst_n,
  input  logic                       i_globstall,
  input  logic [riscv_pkg::XLEN-1:0] i_addr,
  input  logic [riscv_pkg::XLEN-1:0] i_amo_addr,
  input  riscv_pkg::mem_ctrl_t       i_mem_ctrl,
  input  logic                       i_gtrap,
  input  logic [1:0]                 i_rtrap,
  output riscv_pkg::mem_req_t        o_mem_req,
  output logic [riscv_pkg::XLEN-1:0] o_sc_rdvalue
);

  logic                       is_lr;
  logic                       is_sc;
  logic                       trap;
  logic                       sc_ok;
  logic                       resv_valid;
  logic [riscv_pkg::XLEN-1:0] resv_addr;

  assign is_lr = |i_mem_ctrl.lr;
  assign is_sc = |i_mem_ctrl.sc;
  assign trap  = i_gtrap | (|i_rtrap);                   // Entering or leaving a trap

  assign sc_ok = resv_valid && (resv_addr == i_amo_addr);

  assign o_mem_req.addr = (is_lr || is_sc || i_mem_ctrl.amo) ? i_amo_addr : i_addr;
  assign o_mem_req.wren = i_mem_ctrl.memw & ~trap & (~is_sc | sc_ok);
  assign o_mem_req.rden = i_mem_ctrl.memr & ~trap;

  assign o_sc_rdvalue = {{(riscv_pkg::XLEN-1){1'b0}}, ~sc_ok};  // 0 on success

  always_ff @(posedge i_riscv_lsu_clk) begin
    if (!i_rst_n) begin
      resv_valid <= 1'b0;
    end else if (!i_globstall) begin
      if (trap || is_sc) begin
        resv_valid <= 1'b0;                              // SC consumes it either way
      end else if (is_lr) begin
        resv_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_riscv_lsu_clk) begin
    if (!i_globstall && !trap && is_lr) begin
      resv_addr <= i_amo_addr;
    end
  end

  // Decode never issues a read and a write together
  a_no_rd_wr: assert property (@(posedge i_riscv_lsu_clk) disable iff (!i_rst_n)
    !(o_mem_req.wren && o_mem_req.rden));

endmodule

//--- riscv_icu.sv
`timescale 1ns/1ps

module riscv_icu (
  input  logic                       i_riscv_icu_clk,
  input  logic                       i_rst_n,
  input  logic                       i_globstall,
  input  logic [riscv_pkg::XLEN-1:0] i_rs1data,
  input  logic [riscv_pkg::XLEN-1:0] i_rs2data,
  input  logic [riscv_pkg::XLEN-1:0] i_alua,
  input  logic [riscv_pkg::XLEN-1:0] i_alub,
  input  riscv_pkg::alu_op_e         i_aluop,
  input  riscv_pkg::mul_op_e         i_mulop,
  input  riscv_pkg::funcsel_e        i_funcsel,
  input  riscv_pkg::bcond_e          i_bcond,
  output logic                       o_branch_taken,
  output logic                       o_mul_busy,
  output logic                       o_valid,
  output logic [riscv_pkg::XLEN-1:0] o_result
);

  logic [riscv_pkg::XLEN-1:0] alu_y;
  logic [riscv_pkg::XLEN-1:0] mul_y;
  logic                       mul_start;
  logic                       mul_busy;
  logic                       mul_done;
  logic                       cond;

  // The done cycle still holds the finished instruction, so no restart there
  assign mul_start = (i_mulop != riscv_pkg::MUL_NONE) && !i_globstall && !mul_busy && !mul_done;

  always_comb begin
    case (i_bcond)
      riscv_pkg::BC_BEQ:  cond = (i_rs1data == i_rs2data);
      riscv_pkg::BC_BNE:  cond = (i_rs1data != i_rs2data);
      riscv_pkg::BC_BLT:  cond = ($signed(i_rs1data) < $signed(i_rs2data));
      riscv_pkg::BC_BGE:  cond = ($signed(i_rs1data) >= $signed(i_rs2data));
      riscv_pkg::BC_BLTU: cond = (i_rs1data < i_rs2data);
      riscv_pkg::BC_BGEU: cond = (i_rs1data >= i_rs2data);
      riscv_pkg::BC_JUMP: cond = 1'b1;
      default:            cond = 1'b0;
    endcase
  end

  assign o_branch_taken = i_bcond[3] & cond;             // Bit 3 enables the compare

  assign o_result   = (i_funcsel == riscv_pkg::FUNC_MUL) ? mul_y : alu_y;
  assign o_valid    = (i_funcsel == riscv_pkg::FUNC_ALU) ? 1'b1 : mul_done;
  assign o_mul_busy = mul_busy;

  riscv_alu u_alu (
    .i_a  (i_alua),
    .i_b  (i_alub),
    .i_op (i_aluop),
    .o_y  (alu_y)
  );

  riscv_mul u_mul (
    .i_riscv_mul_clk (i_riscv_icu_clk),
    .i_rst_n         (i_rst_n),
    .i_start         (mul_start),
    .i_op            (i_mulop),
    .i_a             (i_rs1data),
    .i_b             (i_rs2data),
    .o_busy          (mul_busy),
    .o_done          (mul_done),
    .o_result        (mul_y)
  );

  // One multiply in flight, finishing exactly after its fixed latency
  a_mul_single_flight: assert property (@(posedge i_riscv_icu_clk) disable iff (!i_rst_n)
    mul_start |=> !mul_start [*(riscv_pkg::MUL_CYCLES + 1)] ##1 (mul_done && !mul_start));

endmodule

//--- riscv_mul.sv
`timescale 1ns/1ps

module riscv_mul (
  input  logic                       i_riscv_mul_clk,
  input  logic                       i_rst_n,
  input  logic                       i_start,
  input  riscv_pkg::mul_op_e         i_op,
  input  logic [riscv_pkg::XLEN-1:0] i_a,
  input  logic [riscv_pkg::XLEN-1:0] i_b,
  output logic                       o_busy,
  output logic                       o_done,
  output logic [riscv_pkg::XLEN-1:0] o_result
);

  typedef enum logic {S_IDLE, S_BUSY} mul_state_e;

  mul_state_e                        state;
  logic [riscv_pkg::MUL_CNT_W-1:0]   cnt;
  logic [2*riscv_pkg::XLEN-1:0]      acc;                // High half sums, low half multiplier
  logic [riscv_pkg::XLEN-1:0]        mcand;
  logic                              neg;
  riscv_pkg::mul_op_e                op_q;
  logic                              a_neg;
  logic                              b_neg;
  logic [riscv_pkg::XLEN-1:0]        a_mag;
  logic [riscv_pkg::XLEN-1:0]        b_mag;
  logic [riscv_pkg::XLEN:0]          sum;
  logic [2*riscv_pkg::XLEN-1:0]      prod;

  // rs1 signed for MULH and MULHSU, rs2 only for MULH
  assign a_neg = i_a[riscv_pkg::XLEN-1] &
                 ((i_op == riscv_pkg::MUL_MULH) || (i_op == riscv_pkg::MUL_MULHSU));
  assign b_neg = i_b[riscv_pkg::XLEN-1] & (i_op == riscv_pkg::MUL_MULH);
  assign a_mag = a_neg ? -i_a : i_a;
  assign b_mag = b_neg ? -i_b : i_b;

  assign sum  = {1'b0, acc[2*riscv_pkg::XLEN-1:riscv_pkg::XLEN]} + {1'b0, mcand};
  assign prod = neg ? -acc : acc;                        // Sign correction
  assign o_busy = (state == S_BUSY);

  always_ff @(posedge i_riscv_mul_clk) begin
    if (!i_rst_n) begin
      state  <= S_IDLE;
      cnt    <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (i_start) begin
            state <= S_BUSY;
            cnt   <= '0;
          end
        end
        S_BUSY: begin
          if (cnt == riscv_pkg::MUL_CYCLES) begin
            state  <= S_IDLE;
            o_done <= 1'b1;                              // One-cycle pulse with the result
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_riscv_mul_clk) begin
    if ((state == S_IDLE) && i_start) begin
      acc   <= {{riscv_pkg::XLEN{1'b0}}, b_mag};
      mcand <= a_mag;
      neg   <= a_neg ^ b_neg;
      op_q  <= i_op;
    end else if (state == S_BUSY) begin
      if (cnt != riscv_pkg::MUL_CYCLES) begin
        acc <= acc[0] ? {sum, acc[riscv_pkg::XLEN-1:1]} : {1'b0, acc[2*riscv_pkg::XLEN-1:1]};
      end else begin
        case (op_q)
          riscv_pkg::MUL_MUL:  o_result <= prod[riscv_pkg::XLEN-1:0];
          riscv_pkg::MUL_MULW: o_result <= {{32{prod[31]}}, prod[31:0]};
          default:             o_result <= prod[2*riscv_pkg::XLEN-1:riscv_pkg::XLEN];
        endcase
      end
    end
  end

endmodule

//--- riscv_alu.sv
`timescale 1ns/1ps

module riscv_alu (
  input  logic [riscv_pkg::XLEN-1:0] i_a,
  input  logic [riscv_pkg::XLEN-1:0] i_b,
  input  riscv_pkg::alu_op_e         i_op,
  output logic [riscv_pkg::XLEN-1:0] o_y
);

  logic [31:0] a_w;
  logic [31:0] b_w;
  logic [31:0] y_w;

  assign a_w = i_a[31:0];
  assign b_w = i_b[31:0];

  // 32-bit results of the W forms
  always_comb begin
    case (i_op)
      riscv_pkg::ALU_ADDW: y_w = a_w + b_w;
      riscv_pkg::ALU_SUBW: y_w = a_w - b_w;
      riscv_pkg::ALU_SLLW: y_w = a_w << b_w[4:0];
      riscv_pkg::ALU_SRLW: y_w = a_w >> b_w[4:0];
      riscv_pkg::ALU_SRAW: y_w = $signed(a_w) >>> b_w[4:0];
      default:             y_w = '0;
    endcase
  end

  always_comb begin
    case (i_op)
      riscv_pkg::ALU_ADD:  o_y = i_a + i_b;
      riscv_pkg::ALU_SUB:  o_y = i_a - i_b;
      riscv_pkg::ALU_SLL:  o_y = i_a << i_b[5:0];
      riscv_pkg::ALU_SLT:  o_y = {{(riscv_pkg::XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
      riscv_pkg::ALU_SLTU: o_y = {{(riscv_pkg::XLEN-1){1'b0}}, i_a < i_b};
      riscv_pkg::ALU_XOR:  o_y = i_a ^ i_b;
      riscv_pkg::ALU_SRL:  o_y = i_a >> i_b[5:0];
      riscv_pkg::ALU_SRA:  o_y = $signed(i_a) >>> i_b[5:0];
      riscv_pkg::ALU_OR:   o_y = i_a | i_b;
      riscv_pkg::ALU_AND:  o_y = i_a & i_b;
      riscv_pkg::ALU_ADDW,
      riscv_pkg::ALU_SUBW,
      riscv_pkg::ALU_SLLW,
      riscv_pkg::ALU_SRLW,
      riscv_pkg::ALU_SRAW: o_y = {{32{y_w[31]}}, y_w};       // Sign-extend word
      riscv_pkg::ALU_LUI:  o_y = i_b;
      riscv_pkg::ALU_JAL:  o_y = i_a + riscv_pkg::XLEN'(4); // Return address
      default:             o_y = '0;
    endcase
  end

endmodule

//--- riscv_pkg.sv
package riscv_pkg;

  localparam int XLEN       = 64;
  localparam int MUL_CYCLES = 64;                       // One iteration per multiplier bit
  localparam int MUL_CNT_W  = $clog2(MUL_CYCLES + 1);

  typedef enum logic [5:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_ADDW,
    ALU_SUBW,
    ALU_SLLW,
    ALU_SRLW,
    ALU_SRAW,
    ALU_LUI,                                            // Pass operand B
    ALU_JAL                                             // Link address, A + 4
  } alu_op_e;

  // Bit 3 marks a control-flow condition
  typedef enum logic [3:0] {
    BC_NONE = 4'b0000,
    BC_BEQ  = 4'b1000,
    BC_BNE  = 4'b1001,
    BC_JUMP = 4'b1010,
    BC_BLT  = 4'b1100,
    BC_BGE  = 4'b1101,
    BC_BLTU = 4'b1110,
    BC_BGEU = 4'b1111
  } bcond_e;

  typedef enum logic [2:0] {
    MUL_NONE,
    MUL_MUL,
    MUL_MULH,
    MUL_MULHSU,
    MUL_MULHU,
    MUL_MULW
  } mul_op_e;

  // All-zero controls form a bubble with no valid result
  typedef enum logic {
    FUNC_MUL = 1'b0,
    FUNC_ALU = 1'b1
  } funcsel_e;

  typedef enum logic [1:0] {
    FWD_REG,
    FWD_WB,
    FWD_MEM,
    FWD_IMM_M
  } fwd_sel_e;

  typedef enum logic [1:0] {
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD,
    SIZE_DOUBLE
  } mem_size_e;

  typedef struct packed {
    fwd_sel_e fwda;
    fwd_sel_e fwdb;
    logic     oprnd1sel;                                // 0 PC, 1 forwarded A
    logic     oprnd2sel;                                // 0 forwarded B, 1 simm
    alu_op_e  aluop;
    mul_op_e  mulop;
    funcsel_e funcsel;
    bcond_e   bcond;
    logic     imm_reg;                                  // CSR data from immediate
    logic     is_branch;
    logic     is_jump;
  } ex_ctrl_t;

  typedef struct packed {
    logic       memw;
    logic       memr;
    logic [1:0] lr;                                     // Bit 1 valid, bit 0 doubleword
    logic [1:0] sc;                                     // Same coding as lr
    logic       amo;
    mem_size_e  size;
  } mem_ctrl_t;

  typedef struct packed {
    logic            wren;
    logic            rden;
    logic [XLEN-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic inst;
    logic load;
    logic store;
  } trap_flags_t;

endpackage
